/* eth_rx_top.f */
+incdir+hw
+incdir+verif
hw/eth_rx_pkg.sv
hw/eth_rx_nibble_pack.sv
hw/eth_rx_parser.sv
hw/eth_rx_crc.sv
hw/eth_rx_buffer.sv
hw/eth_rx_top.sv
verif/eth_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the receive MAC testbench with Verilator and runs it
# the exit status is nonzero when the simulation ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
   -f eth_rx_top.f \
   --top-module eth_rx_tb \
   --Mdir obj_dir -o eth_rx_sim \
   && ./obj_dir/eth_rx_sim \
   || { echo "simulation did not pass"; exit 1; }

/* verif/eth_rx_frame_gen.svh */
`ifndef ETH_RX_FRAME_GEN_SVH
`define ETH_RX_FRAME_GEN_SVH

typedef logic [7:0] byte_q_t [$];

// reflected IEEE 802.3 polynomial
localparam logic [31:0] FCS_POLY = 32'hEDB88320;
localparam int PREAMBLE_LEN = 7;
// 96 bit times on a nibble bus
localparam int IFG_CYCLES = 24;

// reference remainder, all ones start, lsb first, never inverted
function automatic logic [31:0] ref_crc(input byte_q_t data);
   logic [31:0] r;
   logic        fb;
   int          b;
   r = 32'hFFFF_FFFF;
   foreach (data[i]) begin
      for (b = 0; b < 8; b++) begin
         fb = r[0] ^ data[i][b];
         r  = {1'b0, r[31:1]} ^ (fb ? FCS_POLY : 32'h0);
      end
   end
   return r;
endfunction

// FCS goes on the wire inverted, low byte first
task automatic append_fcs(ref byte_q_t data);
   logic [31:0] fcs;
   int          k;
   fcs = ~ref_crc(data);
   for (k = 0; k < 4; k++) begin
      data.push_back(fcs[8*k +: 8]);
   end
endtask

function automatic int random_payload_len();
   return int'($urandom_range(60, 46));
endfunction

// destination, source, type, then random payload
task automatic build_frame(ref byte_q_t data, input logic [47:0] dest,
                           input int payload_len);
   int k;
   data.delete();
   for (k = 5; k >= 0; k--) begin
      data.push_back(dest[8*k +: 8]);
   end
   for (k = 0; k < 6; k++) begin
      data.push_back(8'($urandom));
   end
   data.push_back(8'h08);
   data.push_back(8'h00);
   for (k = 0; k < payload_len; k++) begin
      data.push_back(8'($urandom));
   end
endtask

task automatic drive_nibble(input logic [3:0] nib);
   @(posedge RX_CLK);
   RX_DV   <= 1'b1;
   RX_DATA <= nib;
endtask

// low nibble first on MII
task automatic drive_byte(input logic [7:0] b);
   drive_nibble(b[3:0]);
   drive_nibble(b[7:4]);
endtask

task automatic release_line(input int gap);
   @(posedge RX_CLK);
   RX_DV   <= 1'b0;
   RX_DATA <= 4'h0;
   repeat (gap) @(posedge RX_CLK);
endtask

task automatic send_preamble(input bit with_sfd);
   int k;
   for (k = 0; k < PREAMBLE_LEN; k++) begin
      drive_byte(8'h55);
   end
   drive_byte(with_sfd ? `ETH_SFD : 8'h55);
endtask

task automatic send_frame(input byte_q_t data, input bit odd_tail,
                          input logic [3:0] tail);
   send_preamble(1'b1);
   foreach (data[i]) begin
      drive_byte(data[i]);
   end
   if (odd_tail) begin
      drive_nibble(tail);
   end
   release_line(IFG_CYCLES);
endtask

`endif

/* verif/eth_rx_tb.sv */
`timescale 1ns/1ps

`include "eth_rx_defs.svh"

module eth_rx_tb;

   import eth_rx_pkg::*;

   localparam int RCV_TIMEOUT = 400;
   localparam int QUIET_CYCLES = 300;
   localparam logic [31:0] GOOD_RESIDUE = 32'hDEBB20E3;

   logic        RX_CLK;
   logic        rx_rst;
   logic        RX_DV;
   logic [3:0]  RX_DATA;
   logic        rcv_ack;
   buf_addr_t   rd_addr;
   logic        data_rcvd;
   buf_addr_t   frame_len;
   logic [31:0] crc_value;
   logic [7:0]  rd_data;

   // high only while a matching frame may be held
   bit rx_expected;

   eth_rx_top u_eth_rx_top (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .RX_DV     (RX_DV),
      .RX_DATA   (RX_DATA),
      .rcv_ack   (rcv_ack),
      .rd_addr   (rd_addr),
      .data_rcvd (data_rcvd),
      .frame_len (frame_len),
      .crc_value (crc_value),
      .rd_data   (rd_data)
   );

   always #20 RX_CLK = ~RX_CLK;

   `include "eth_rx_frame_gen.svh"

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   assert property (@(posedge RX_CLK) disable iff (rx_rst) !rx_expected |-> !data_rcvd)
      else abort_run($sformatf("mismatch at %0t: data_rcvd high for no matching frame",
                               $time));

   // held frame frozen until the host acks
   assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (data_rcvd && !rcv_ack) |=> (data_rcvd && $stable(frame_len) && $stable(crc_value)))
      else abort_run($sformatf("mismatch at %0t: held frame changed before rcv_ack", $time));

   assert property (@(posedge RX_CLK) disable iff (rx_rst) (data_rcvd && rcv_ack) |=> !data_rcvd)
      else abort_run($sformatf("mismatch at %0t: data_rcvd stayed high after rcv_ack", $time));

   task automatic wait_for_rcvd(input logic level, input string what);
      int n;
      n = 0;
      @(negedge RX_CLK);
      while (data_rcvd !== level) begin
         if (n == RCV_TIMEOUT) begin
            abort_run($sformatf("timed out waiting for %s", what));
         end
         n++;
         @(negedge RX_CLK);
      end
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge RX_CLK);
         assert (data_rcvd == 1'b0)
            else abort_run($sformatf("mismatch at %0t: data_rcvd rose unexpectedly", $time));
      end
   endtask

   // length first, then every stored byte through the read port
   task automatic check_frame(input byte_q_t exp);
      @(negedge RX_CLK);
      assert (frame_len == buf_addr_t'(exp.size()))
         else abort_run($sformatf("mismatch at %0t: frame_len %0d, expected %0d",
                                  $time, frame_len, exp.size()));
      foreach (exp[i]) begin
         @(posedge RX_CLK);
         rd_addr <= buf_addr_t'(`ETH_RX_BUFFER_START + i);
         @(posedge RX_CLK);
         @(negedge RX_CLK);
         assert (rd_data == exp[i])
            else abort_run($sformatf("mismatch at %0t: byte %0d read %h, expected %h",
                                     $time, i, rd_data, exp[i]));
      end
   endtask

   task automatic ack_frame();
      @(posedge RX_CLK);
      rcv_ack <= 1'b1;
      @(posedge RX_CLK);
      rcv_ack <= 1'b0;
      wait_for_rcvd(1'b0, "data_rcvd to fall after rcv_ack");
      rx_expected = 1'b0;
   endtask

   task automatic check_crc(input logic [31:0] exp);
      assert (crc_value == exp)
         else abort_run($sformatf("mismatch at %0t: crc_value %h, expected %h",
                                  $time, crc_value, exp));
   endtask

   initial begin
      byte_q_t     frame_a;
      byte_q_t     frame_b;
      logic [47:0] other_addr;
      RX_CLK      = 1'b0;
      rx_rst      = 1'b1;
      RX_DV       = 1'b0;
      RX_DATA     = 4'h0;
      rcv_ack     = 1'b0;
      rd_addr     = '0;
      rx_expected = 1'b0;
      void'($urandom(32'he6884b65));
      repeat (2) @(posedge RX_CLK);
      rx_rst <= 1'b0;

      // idle line, then a preamble that never reaches the SFD
      expect_quiet(50);
      send_preamble(1'b0);
      release_line(IFG_CYCLES);
      expect_quiet(50);

      // matching frame with a good FCS
      build_frame(frame_a, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_a);
      rx_expected = 1'b1;
      send_frame(frame_a, 1'b0, 4'h0);
      wait_for_rcvd(1'b1, "data_rcvd on a good frame");
      check_crc(GOOD_RESIDUE);
      check_frame(frame_a);
      ack_frame();

      // corrupted FCS byte
      build_frame(frame_a, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_a);
      frame_a[frame_a.size()-2] = frame_a[frame_a.size()-2] ^ 8'h5A;
      rx_expected = 1'b1;
      send_frame(frame_a, 1'b0, 4'h0);
      wait_for_rcvd(1'b1, "data_rcvd on a bad FCS frame");
      check_crc(ref_crc(frame_a));
      check_frame(frame_a);
      ack_frame();

      // foreign destination is dropped, the next match still lands
      other_addr = `ETH_MAC_ADDR ^ 48'h0000_0000_0100;
      build_frame(frame_b, other_addr, random_payload_len());
      append_fcs(frame_b);
      send_frame(frame_b, 1'b0, 4'h0);
      expect_quiet(QUIET_CYCLES);
      build_frame(frame_a, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_a);
      rx_expected = 1'b1;
      send_frame(frame_a, 1'b0, 4'h0);
      wait_for_rcvd(1'b1, "data_rcvd after a dropped frame");
      check_frame(frame_a);
      ack_frame();

      // second frame while one is held
      build_frame(frame_a, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_a);
      rx_expected = 1'b1;
      send_frame(frame_a, 1'b0, 4'h0);
      wait_for_rcvd(1'b1, "data_rcvd on the frame to hold");
      build_frame(frame_b, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_b);
      send_frame(frame_b, 1'b0, 4'h0);
      @(negedge RX_CLK);
      assert (data_rcvd == 1'b1)
         else abort_run($sformatf("mismatch at %0t: held frame was released", $time));
      check_crc(GOOD_RESIDUE);
      check_frame(frame_a);
      ack_frame();
      build_frame(frame_b, `ETH_MAC_ADDR, random_payload_len());
      append_fcs(frame_b);
      rx_expected = 1'b1;
      send_frame(frame_b, 1'b0, 4'h0);
      wait_for_rcvd(1'b1, "data_rcvd after rcv_ack");
      check_frame(frame_b);
      ack_frame();

      // trailing odd nibble is not stored
      build_frame(frame_a, `ETH_MAC_ADDR, random_payload_len());
      rx_expected = 1'b1;
      send_frame(frame_a, 1'b1, 4'hA);
      wait_for_rcvd(1'b1, "data_rcvd on an odd nibble frame");
      check_crc(ref_crc(frame_a));
      check_frame(frame_a);
      ack_frame();

      $display("Everything OK");
      $finish;
   end

endmodule

/* hw/eth_rx_top.sv */
`timescale 1ns/1ps

module eth_rx_top (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  RX_DV,
   input  logic [3:0]            RX_DATA,
   input  logic                  rcv_ack,
   input  eth_rx_pkg::buf_addr_t rd_addr,
   output logic                  data_rcvd,
   output eth_rx_pkg::buf_addr_t frame_len,
   output logic [31:0]           crc_value,
   output logic [7:0]            rd_data
);

   import eth_rx_pkg::*;

   logic       byte_valid;
   logic [7:0] byte_data;
   logic       sof;
   logic       eof;
   logic       wr;
   buf_addr_t  wr_addr;
   logic [7:0] wr_data;
   logic       crc_start;

   // MII nibbles to bytes
   eth_rx_nibble_pack u_nibble_pack (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .RX_DV      (RX_DV),
      .RX_DATA    (RX_DATA),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .sof        (sof),
      .eof        (eof)
   );

   eth_rx_parser u_parser (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .sof        (sof),
      .eof        (eof),
      .rcv_ack    (rcv_ack),
      .wr         (wr),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .crc_start  (crc_start),
      .data_rcvd  (data_rcvd),
      .frame_len  (frame_len)
   );

   // crc runs over exactly the bytes that are stored
   eth_rx_crc u_crc (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .start     (crc_start),
      .data_en   (wr),
      .data_in   (wr_data),
      .crc_value (crc_value)
   );

   eth_rx_buffer u_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* hw/eth_rx_buffer.sv */
`timescale 1ns/1ps

`include "eth_rx_defs.svh"

module eth_rx_buffer (
   input  logic                  RX_CLK,
   input  logic                  wr,
   input  eth_rx_pkg::buf_addr_t wr_addr,
   input  logic [7:0]            wr_data,
   input  eth_rx_pkg::buf_addr_t rd_addr,
   output logic [7:0]            rd_data
);

   localparam int DEPTH = 1 << `ETH_RX_BUF_AW;

   logic [7:0] mem [0:DEPTH-1];

   // write side, driven by the parser
   always_ff @(posedge RX_CLK) begin
      if (wr) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // host read, one cycle latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* hw/eth_rx_crc.sv */
`timescale 1ns/1ps

module eth_rx_crc (
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  logic        start,
   input  logic        data_en,
   input  logic [7:0]  data_in,
   output logic [31:0] crc_value
);

   // reflected form of the IEEE 802.3 polynomial
   localparam logic [31:0] CRC_POLY = 32'hEDB88320;

   logic [31:0] crc_next;

   // one byte, lsb first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                            input logic [7:0]  data);
      logic [31:0] c;
      int          i;
      c = crc_in;
      for (i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   assign crc_next = crc_byte(crc_value, data_in);

   // no final inversion, a good frame leaves the residue 32'hDEBB20E3
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_value <= 32'hFFFF_FFFF;
      end else if (start) begin
         crc_value <= 32'hFFFF_FFFF;
      end else if (data_en) begin
         crc_value <= crc_next;
      end
   end

endmodule

/* hw/eth_rx_parser.sv */
`timescale 1ns/1ps

`include "eth_rx_defs.svh"

module eth_rx_parser #(
   parameter logic [47:0] MAC_ADDR = `ETH_MAC_ADDR
) (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  byte_valid,
   input  logic [7:0]            byte_data,
   input  logic                  sof,
   input  logic                  eof,
   input  logic                  rcv_ack,
   output logic                  wr,
   output eth_rx_pkg::buf_addr_t wr_addr,
   output logic [7:0]            wr_data,
   output logic                  crc_start,
   output logic                  data_rcvd,
   output eth_rx_pkg::buf_addr_t frame_len
);

   import eth_rx_pkg::*;

   localparam buf_addr_t BUF_START = buf_addr_t'(`ETH_RX_BUFFER_START);
   localparam logic [2:0] LAST_ADDR_BYTE = 3'(`MAC_ADDR_LEN - 1);

   rx_state_t   state;
   buf_addr_t   next_addr;
   logic [2:0]  addr_cnt;
   logic [47:0] dest_shift;
   logic [47:0] dest_next;
   logic        storing;

   // address bytes arrive most significant first
   assign dest_next = {dest_shift[39:0], byte_data};

   assign storing   = (state == dest_addr) || (state == payload);
   assign crc_start = (state == idle);

   always_ff @(posedge RX_CLK) begin
      if (byte_valid) begin
         dest_shift <= dest_next;
         wr_data    <= byte_data;
         wr_addr    <= next_addr;
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state     <= idle;
         next_addr <= BUF_START;
         addr_cnt  <= 3'd0;
         wr        <= 1'b0;
         data_rcvd <= 1'b0;
         frame_len <= '0;
      end else begin
         wr <= byte_valid && storing;

         if (byte_valid && storing) begin
            next_addr <= next_addr + 1'b1;
         end

         case (state)
            idle: begin
               if (sof) begin
                  state     <= dest_addr;
                  next_addr <= BUF_START;
                  addr_cnt  <= 3'd0;
               end
            end

            dest_addr: begin
               if (eof) begin
                  // runt frame, shorter than an address
                  state <= idle;
               end else if (byte_valid) begin
                  addr_cnt <= addr_cnt + 1'b1;
                  if (addr_cnt == LAST_ADDR_BYTE) begin
                     state <= (dest_next == MAC_ADDR) ? payload : drop;
                  end
               end
            end

            payload: begin
               if (eof) begin
                  frame_len <= next_addr - BUF_START;
                  data_rcvd <= 1'b1;
                  state     <= hold;
               end
            end

            drop: begin
               if (eof) begin
                  state <= idle;
               end
            end

            hold: begin
               // frame stays put until the host lets go
               if (rcv_ack) begin
                  data_rcvd <= 1'b0;
                  state     <= idle;
               end
            end

            default: begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

/* hw/eth_rx_nibble_pack.sv */
`timescale 1ns/1ps

`include "eth_rx_defs.svh"

module eth_rx_nibble_pack (
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       RX_DV,
   input  logic [3:0] RX_DATA,
   output logic       byte_valid,
   output logic [7:0] byte_data,
   output logic       sof,
   output logic       eof
);

   logic       rx_dv_q;
   logic [3:0] rx_data_q;
   logic [3:0] nib_prev;
   logic [7:0] byte_now;
   logic       in_frame;
   logic       phase;

   // last two nibbles, newest in the high half
   assign byte_now = {rx_data_q, nib_prev};

   always_ff @(posedge RX_CLK) begin
      rx_data_q <= RX_DATA;
      nib_prev  <= rx_dv_q ? rx_data_q : 4'h0;
      if (rx_dv_q) begin
         byte_data <= byte_now;
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rx_dv_q    <= 1'b0;
         in_frame   <= 1'b0;
         phase      <= 1'b0;
         byte_valid <= 1'b0;
         sof        <= 1'b0;
         eof        <= 1'b0;
      end else begin
         rx_dv_q    <= RX_DV;
         byte_valid <= 1'b0;
         sof        <= 1'b0;
         eof        <= 1'b0;
         if (!in_frame) begin
            // hunt for the delimiter, this also aligns the nibble pairs
            if (rx_dv_q && byte_now == `ETH_SFD) begin
               in_frame <= 1'b1;
               phase    <= 1'b0;
               sof      <= 1'b1;
            end
         end else if (!rx_dv_q) begin
            in_frame <= 1'b0;
            eof      <= 1'b1;
         end else begin
            // second nibble of a pair completes a byte
            phase      <= ~phase;
            byte_valid <= phase;
         end
      end
   end

endmodule

/* hw/eth_rx_pkg.sv */
`include "eth_rx_defs.svh"

package eth_rx_pkg;

   // receive frame states
   typedef enum logic [2:0] {
      idle      = 3'd0,
      dest_addr = 3'd1,
      payload   = 3'd2,
      drop      = 3'd3,
      hold      = 3'd4
   } rx_state_t;

   // buffer address, also used for the frame length
   typedef logic [`ETH_RX_BUF_AW-1:0] buf_addr_t;

endpackage

/* hw/eth_rx_defs.svh */
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// start-of-frame delimiter as seen after nibble packing
`define ETH_SFD 8'hD5

// station address, first byte on the wire is the most significant
`define ETH_MAC_ADDR 48'h01_60_6E_11_02_0F

// destination address length in bytes
`define MAC_ADDR_LEN 6

// receive buffer geometry
`define ETH_RX_BUF_AW 11
`define ETH_RX_BUFFER_START 0

`endif
